//--- include/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// datapath width, fixed by the instruction set
`define EXEC_DW 32

// shift amount field width
`define EXEC_SAW 5

// one restoring step per quotient bit
`define EXEC_DIV_ITERS 32

`endif

//--- logic/exec_pkg.sv
`default_nettype none

`include "exec_defines.svh"

package exec_pkg;

	// operation codes seen by the execute stage
	typedef enum logic [4:0] {
		op_and,
		op_or,
		op_xor,
		op_nor,
		op_lui,
		op_sll,
		op_srl,
		op_sra,
		op_sllv,
		op_srlv,
		op_srav,
		op_add,
		op_addu,
		op_sub,
		op_subu,
		op_slt,
		op_sltu,
		op_mfhi,
		op_mflo,
		op_mthi,
		op_mtlo,
		op_mult,
		op_multu,
		op_div,
		op_divu,
		op_beq,
		op_bne,
		op_bgtz,
		op_blez,
		op_bltz,
		op_bgez
	} alu_op_e;

	typedef enum logic [2:0] {
		s_idle,
		s_alu,
		s_mul,
		s_div,
		s_resp
	} exec_state_e;

	// hi/lo write source
	typedef enum logic [2:0] {
		hs_none,
		hs_mul,
		hs_div,
		hs_hi,
		hs_lo
	} hilo_src_e;

	typedef struct packed {
		alu_op_e                op;
		logic [`EXEC_DW-1:0]    a;
		logic [`EXEC_DW-1:0]    b;
		logic [`EXEC_SAW-1:0]   sa;
	} exec_req_t;

	typedef struct packed {
		logic [`EXEC_DW-1:0]    result;
		logic                   overflow;
		logic                   taken;
	} exec_rsp_t;

	typedef struct packed {
		logic [`EXEC_DW-1:0]    hi;
		logic [`EXEC_DW-1:0]    lo;
	} hilo_t;

endpackage

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

module alu (
	input  exec_pkg::alu_op_e       op,
	input  logic [`EXEC_DW-1:0]     a,
	input  logic [`EXEC_DW-1:0]     b,
	input  logic [`EXEC_SAW-1:0]    sa,
	input  exec_pkg::hilo_t         hilo,
	output logic [`EXEC_DW-1:0]     result,
	output logic                    overflow,
	output logic                    taken
);
	import exec_pkg::*;

	localparam int MSB = `EXEC_DW - 1;

	logic [`EXEC_DW-1:0] sum;
	logic [`EXEC_DW-1:0] diff;
	logic [`EXEC_DW-1:0] ans;
	logic [`EXEC_SAW-1:0] var_sa;
	logic add_ovf;
	logic sub_ovf;
	logic a_zero;

	assign sum = a + b;
	assign diff = a - b;

	// variable shifts take the amount from the low bits of a
	assign var_sa = a[`EXEC_SAW-1:0];

	// same-sign inputs giving a result of the other sign
	assign add_ovf = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
	assign sub_ovf = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);

	assign overflow = ((op == op_add) && add_ovf) || ((op == op_sub) && sub_ovf);

	// trapped arithmetic writes nothing useful
	assign result = overflow ? '0 : ans;

	assign a_zero = (a == '0);

	always_comb begin
		unique case (op)
			op_and:  ans = a & b;
			op_or:   ans = a | b;
			op_xor:  ans = a ^ b;
			op_nor:  ans = ~(a | b);
			op_lui:  ans = {b[15:0], 16'h0000};

			op_sll:  ans = b << sa;
			op_srl:  ans = b >> sa;
			op_sra:  ans = $signed(b) >>> sa;
			op_sllv: ans = b << var_sa;
			op_srlv: ans = b >> var_sa;
			op_srav: ans = $signed(b) >>> var_sa;

			op_add, op_addu: ans = sum;
			op_sub, op_subu: ans = diff;
			op_slt:  ans = {{(`EXEC_DW-1){1'b0}}, $signed(a) < $signed(b)};
			op_sltu: ans = {{(`EXEC_DW-1){1'b0}}, a < b};

			op_mfhi: ans = hilo.hi;
			op_mflo: ans = hilo.lo;
			// moves to hi/lo echo the written word
			op_mthi, op_mtlo: ans = a;

			op_beq, op_bne: ans = diff;

			default: ans = '0;
		endcase
	end

	// branch condition, b is only used by beq/bne
	always_comb begin
		unique case (op)
			op_beq:  taken = (a == b);
			op_bne:  taken = (a != b);
			op_bgtz: taken = !a[MSB] && !a_zero;
			op_blez: taken = a[MSB] || a_zero;
			op_bltz: taken = a[MSB];
			op_bgez: taken = !a[MSB];
			default: taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/mul_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

module mul_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start,
	input  logic                    signed_op,
	input  logic [`EXEC_DW-1:0]     a,
	input  logic [`EXEC_DW-1:0]     b,
	output logic                    done,
	output exec_pkg::hilo_t         product
);

	// one extra bit so a single signed multiply covers both flavours
	logic signed [`EXEC_DW:0] a_q;
	logic signed [`EXEC_DW:0] b_q;
	logic signed [2*`EXEC_DW+1:0] prod_full;
	logic stage_q;

	assign prod_full = a_q * b_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage_q <= 1'b0;
			done <= 1'b0;
		end else begin
			stage_q <= start;
			done <= stage_q;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			a_q <= {signed_op & a[`EXEC_DW-1], a};
			b_q <= {signed_op & b[`EXEC_DW-1], b};
		end
		// product holds until the next multiply
		if (stage_q) begin
			product <= prod_full[2*`EXEC_DW-1:0];
		end
	end

endmodule

`default_nettype wire

//--- logic/div_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

module div_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start,
	input  logic                    signed_op,
	input  logic [`EXEC_DW-1:0]     a,
	input  logic [`EXEC_DW-1:0]     b,
	output logic                    busy,
	output logic                    done,
	output exec_pkg::hilo_t         quot_rem
);

	localparam int MSB = `EXEC_DW - 1;
	localparam int CNT_W = $clog2(`EXEC_DIV_ITERS);

	logic [`EXEC_DW-1:0] a_abs;
	logic [`EXEC_DW-1:0] b_abs;
	logic [`EXEC_DW-1:0] rem_q;
	logic [`EXEC_DW-1:0] quot_q;
	logic [`EXEC_DW-1:0] dvsr_q;
	logic quot_neg_q;
	logic rem_neg_q;
	logic [CNT_W-1:0] cnt_q;
	logic [`EXEC_DW+1:0] trial;
	logic borrow;

	assign a_abs = (signed_op && a[MSB]) ? -a : a;
	assign b_abs = (signed_op && b[MSB]) ? -b : b;

	// shift in the next dividend bit and try the subtraction
	assign trial = {1'b0, rem_q, quot_q[MSB]} - {2'b00, dvsr_q};
	assign borrow = trial[`EXEC_DW+1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			cnt_q <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cnt_q <= '0;
			end else if (busy) begin
				cnt_q <= cnt_q + 1'b1;
				// last step, result is valid next cycle
				if (cnt_q == CNT_W'(`EXEC_DIV_ITERS - 1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// quotient bits enter from the right as dividend bits leave
	always_ff @(posedge clk) begin
		if (start) begin
			rem_q <= '0;
			quot_q <= a_abs;
			dvsr_q <= b_abs;
			quot_neg_q <= signed_op & (a[MSB] ^ b[MSB]);
			rem_neg_q <= signed_op & a[MSB];
		end else if (busy) begin
			if (borrow) begin
				rem_q <= {rem_q[MSB-1:0], quot_q[MSB]};
			end else begin
				rem_q <= trial[MSB:0];
			end
			quot_q <= {quot_q[MSB-1:0], ~borrow};
		end
	end

	// sign fix-up, remainder follows the dividend
	assign quot_rem.hi = rem_neg_q ? -rem_q : rem_q;
	assign quot_rem.lo = quot_neg_q ? -quot_q : quot_q;

endmodule

`default_nettype wire

//--- logic/hilo_reg.sv
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

module hilo_reg (
	input  logic                    clk,
	input  logic                    rst_n,
	input  exec_pkg::hilo_src_e     wr_src,
	input  logic [`EXEC_DW-1:0]     wr_word,
	input  exec_pkg::hilo_t         mul_val,
	input  exec_pkg::hilo_t         div_val,
	output exec_pkg::hilo_t         hilo
);
	import exec_pkg::*;

	hilo_t hilo_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hilo_q <= '0;
		end else begin
			unique case (wr_src)
				hs_mul:  hilo_q <= mul_val;
				hs_div:  hilo_q <= div_val;
				// single word moves leave the other half alone
				hs_hi:   hilo_q.hi <= wr_word;
				hs_lo:   hilo_q.lo <= wr_word;
				default: hilo_q <= hilo_q;
			endcase
		end
	end

	assign hilo = hilo_q;

endmodule

`default_nettype wire

//--- logic/exec_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

module exec_ctrl (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    req,
	input  exec_pkg::exec_req_t     req_data,
	output logic                    ack,
	output exec_pkg::exec_rsp_t     rsp,
	output exec_pkg::alu_op_e       alu_op,
	output logic [`EXEC_DW-1:0]     op_a,
	output logic [`EXEC_DW-1:0]     op_b,
	output logic [`EXEC_SAW-1:0]    op_sa,
	input  logic [`EXEC_DW-1:0]     alu_result,
	input  logic                    alu_overflow,
	input  logic                    alu_taken,
	output logic                    mul_start,
	output logic                    div_start,
	output logic                    md_signed,
	input  logic                    mul_done,
	input  logic                    div_done,
	output exec_pkg::hilo_src_e     wr_src,
	output logic [`EXEC_DW-1:0]     wr_word
);
	import exec_pkg::*;

	exec_state_e state_q;
	exec_req_t req_q;

	// request is captured once, when it is first seen in idle
	always_ff @(posedge clk) begin
		if (state_q == s_idle && req) begin
			req_q <= req_data;
		end
	end

	assign alu_op = req_q.op;
	assign op_a = req_q.a;
	assign op_b = req_q.b;
	assign op_sa = req_q.sa;
	assign wr_word = req_q.a;
	assign md_signed = (req_q.op == op_mult) || (req_q.op == op_div);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= s_idle;
			ack <= 1'b0;
			rsp <= '0;
			mul_start <= 1'b0;
			div_start <= 1'b0;
			wr_src <= hs_none;
		end else begin
			// starts and hi/lo writes are single-cycle pulses
			mul_start <= 1'b0;
			div_start <= 1'b0;
			wr_src <= hs_none;

			unique case (state_q)
				s_idle: begin
					if (req) begin
						unique case (req_data.op)
							op_mult, op_multu: begin
								mul_start <= 1'b1;
								state_q <= s_mul;
							end
							op_div, op_divu: begin
								div_start <= 1'b1;
								state_q <= s_div;
							end
							default: state_q <= s_alu;
						endcase
					end
				end
				s_alu: begin
					rsp <= '{result: alu_result, overflow: alu_overflow, taken: alu_taken};
					if (req_q.op == op_mthi) begin
						wr_src <= hs_hi;
					end else if (req_q.op == op_mtlo) begin
						wr_src <= hs_lo;
					end
					state_q <= s_resp;
				end
				// multiply and divide only write hi/lo
				s_mul: begin
					if (mul_done) begin
						rsp <= '0;
						wr_src <= hs_mul;
						ack <= 1'b1;
						state_q <= s_resp;
					end
				end
				s_div: begin
					if (div_done) begin
						rsp <= '0;
						wr_src <= hs_div;
						ack <= 1'b1;
						state_q <= s_resp;
					end
				end
				s_resp: begin
					// hold the response as long as req stays high
					if (!ack) begin
						ack <= 1'b1;
					end else if (!req) begin
						ack <= 1'b0;
						state_q <= s_idle;
					end
				end
				default: state_q <= s_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/exec_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

module exec_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    req,
	input  exec_pkg::exec_req_t     req_data,
	output logic                    ack,
	output exec_pkg::exec_rsp_t     rsp
);
	import exec_pkg::*;

	alu_op_e alu_op;
	logic [`EXEC_DW-1:0] op_a;
	logic [`EXEC_DW-1:0] op_b;
	logic [`EXEC_SAW-1:0] op_sa;
	logic [`EXEC_DW-1:0] alu_result;
	logic alu_overflow;
	logic alu_taken;
	logic mul_start;
	logic div_start;
	logic md_signed;
	logic mul_done;
	logic div_done;
	hilo_src_e wr_src;
	logic [`EXEC_DW-1:0] wr_word;
	hilo_t mul_val;
	hilo_t div_val;
	hilo_t hilo_val;

	exec_ctrl u_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.req          (req),
		.req_data     (req_data),
		.ack          (ack),
		.rsp          (rsp),
		.alu_op       (alu_op),
		.op_a         (op_a),
		.op_b         (op_b),
		.op_sa        (op_sa),
		.alu_result   (alu_result),
		.alu_overflow (alu_overflow),
		.alu_taken    (alu_taken),
		.mul_start    (mul_start),
		.div_start    (div_start),
		.md_signed    (md_signed),
		.mul_done     (mul_done),
		.div_done     (div_done),
		.wr_src       (wr_src),
		.wr_word      (wr_word)
	);

	alu u_alu (
		.op       (alu_op),
		.a        (op_a),
		.b        (op_b),
		.sa       (op_sa),
		.hilo     (hilo_val),
		.result   (alu_result),
		.overflow (alu_overflow),
		.taken    (alu_taken)
	);

	mul_unit u_mul (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (mul_start),
		.signed_op (md_signed),
		.a         (op_a),
		.b         (op_b),
		.done      (mul_done),
		.product   (mul_val)
	);

	// busy is a status output, the controller waits on done
	div_unit u_div (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (div_start),
		.signed_op (md_signed),
		.a         (op_a),
		.b         (op_b),
		.busy      (),
		.done      (div_done),
		.quot_rem  (div_val)
	);

	hilo_reg u_hilo (
		.clk     (clk),
		.rst_n   (rst_n),
		.wr_src  (wr_src),
		.wr_word (wr_word),
		.mul_val (mul_val),
		.div_val (div_val),
		.hilo    (hilo_val)
	);

endmodule

`default_nettype wire

//--- testbench/exec_assert.sv
`timescale 1ns/10ps
`default_nettype none

module exec_assert (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 req,
	input logic                 ack,
	input exec_pkg::exec_rsp_t  rsp
);

	int unsigned fail_count = 0;

	// ack only answers a pending request
	assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> req)
	else begin
		fail_count++;
		$error("ack rose while req was low");
	end

	assert property (@(posedge clk) disable iff (!rst_n) $fell(ack) |-> !$past(req))
	else begin
		fail_count++;
		$error("ack fell before req was low");
	end

	// response is frozen for the whole ack phase
	assert property (@(posedge clk) disable iff (!rst_n) ($past(ack) && ack) |-> $stable(rsp))
	else begin
		fail_count++;
		$error("rsp changed while ack was high");
	end

	assert property (@(posedge clk) $rose(rst_n) |-> !ack)
	else begin
		fail_count++;
		$error("ack was high right after reset");
	end

endmodule

bind exec_top exec_assert u_assert (
	.clk   (clk),
	.rst_n (rst_n),
	.req   (req),
	.ack   (ack),
	.rsp   (rsp)
);

`default_nettype wire

//--- testbench/exec_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "exec_defines.svh"

module exec_tb;
	import exec_pkg::*;

	localparam logic [31:0] SEED = 32'h59ceddd8;
	// move 10, logic/shift 44, arith 24, branch 30, mul 24, div 30
	localparam int NUM_TXNS = 10 + 44 + 24 + 30 + 24 + 30;
	localparam int TIMEOUT = (NUM_TXNS + 2) * 40;

	logic clk;
	logic rst_n;
	logic req;
	exec_req_t req_data;
	logic ack;
	exec_rsp_t rsp;

	logic [31:0] lfsr;
	logic [31:0] ref_hi;
	logic [31:0] ref_lo;
	int cycles;

	exec_top uut (
		.clk      (clk),
		.rst_n    (rst_n),
		.req      (req),
		.req_data (req_data),
		.ack      (ack),
		.rsp      (rsp)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// each transaction gets up to 40 cycles
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT && uut.u_assert.fail_count == 0) begin
			@(posedge clk);
			cycles++;
		end
		if (uut.u_assert.fail_count != 0) begin
			$display("error: a protocol assertion failed before time %0t", $time);
		end else begin
			$display("timeout: the DUT did not finish the tests within %0d cycles", TIMEOUT);
		end
		$display("Simulation failed");
		$fatal(1);
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] w);
		w = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			w = {w[30:0], lfsr[0]};
		end
	endtask

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("mismatch at time %0t: %s, got %h, expected %h", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// expected response by the instruction set rules
	function automatic exec_rsp_t expected_rsp(input alu_op_e op, input logic [31:0] a,
			input logic [31:0] b, input logic [4:0] sa);
		exec_rsp_t r;
		logic [32:0] wide;
		r = '0;
		case (op)
			op_and:  r.result = a & b;
			op_or:   r.result = a | b;
			op_xor:  r.result = a ^ b;
			op_nor:  r.result = ~(a | b);
			op_lui:  r.result = {b[15:0], 16'h0000};
			op_sll:  r.result = b << sa;
			op_srl:  r.result = b >> sa;
			op_sra:  r.result = $signed(b) >>> sa;
			op_sllv: r.result = b << a[4:0];
			op_srlv: r.result = b >> a[4:0];
			op_srav: r.result = $signed(b) >>> a[4:0];
			op_add, op_sub: begin
				// top two bits of the 33-bit signed sum differ on overflow
				wide = (op == op_add) ? {a[31], a} + {b[31], b} : {a[31], a} - {b[31], b};
				r.overflow = wide[32] ^ wide[31];
				r.result = r.overflow ? 32'h0 : wide[31:0];
			end
			op_addu: r.result = a + b;
			op_subu: r.result = a - b;
			op_slt:  r.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			op_sltu: r.result = (a < b) ? 32'd1 : 32'd0;
			op_mfhi: r.result = ref_hi;
			op_mflo: r.result = ref_lo;
			op_mthi, op_mtlo: r.result = a;
			op_beq: begin
				r.result = a - b;
				r.taken = (a == b);
			end
			op_bne: begin
				r.result = a - b;
				r.taken = (a != b);
			end
			op_bgtz: r.taken = ($signed(a) > 0);
			op_blez: r.taken = ($signed(a) <= 0);
			op_bltz: r.taken = ($signed(a) < 0);
			op_bgez: r.taken = ($signed(a) >= 0);
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic update_hilo(input alu_op_e op, input logic [31:0] a, input logic [31:0] b);
		logic [63:0] prod;
		logic [31:0] ma;
		logic [31:0] mb;
		logic [31:0] q;
		logic [31:0] rm;
		logic sgn;
		sgn = (op == op_mult) || (op == op_div);
		case (op)
			op_mult, op_multu: begin
				prod = {{32{sgn & a[31]}}, a} * {{32{sgn & b[31]}}, b};
				ref_hi = prod[63:32];
				ref_lo = prod[31:0];
			end
			op_div, op_divu: begin
				ma = (sgn && a[31]) ? -a : a;
				mb = (sgn && b[31]) ? -b : b;
				// divide by zero gives all ones and the dividend back
				q = (mb == 0) ? 32'hffffffff : ma / mb;
				rm = (mb == 0) ? ma : ma % mb;
				ref_lo = (sgn && (a[31] != b[31])) ? -q : q;
				ref_hi = (sgn && a[31]) ? -rm : rm;
			end
			op_mthi: ref_hi = a;
			op_mtlo: ref_lo = a;
			default: ;
		endcase
	endtask

	// one four-phase transaction with req held for hold cycles after ack
	task automatic do_op(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
			input logic [4:0] sa, input int hold, output exec_rsp_t got, output int lat);
		lat = 0;
		@(posedge clk);
		req <= 1'b1;
		req_data <= '{op: op, a: a, b: b, sa: sa};
		// edge 0 samples the request
		@(posedge clk);
		do begin
			@(posedge clk);
			lat++;
		end while (!ack);
		lat = lat - 1;
		got = rsp;
		for (int i = 0; i < hold; i++) begin
			@(posedge clk);
			check_eq(ack, 1'b1, "ack held while req high");
			check_eq(rsp, got, "rsp held while ack high");
		end
		req <= 1'b0;
		do begin
			@(posedge clk);
		end while (ack);
	endtask

	task automatic run_check(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
			input logic [4:0] sa, input int hold, output exec_rsp_t got);
		exec_rsp_t exp;
		int lat;
		exp = expected_rsp(op, a, b, sa);
		do_op(op, a, b, sa, hold, got, lat);
		check_eq(got, exp, op.name());
		if (op == op_mult || op == op_multu) begin
			check_eq(lat, 3, "multiply ack latency");
		end else if (op == op_div || op == op_divu) begin
			check_eq(lat inside {[33:34]}, 1'b1, "divide ack latency");
		end else begin
			check_eq(lat, 2, "alu ack latency");
		end
		update_hilo(op, a, b);
	endtask

	task automatic test_move();
		exec_rsp_t got;
		logic [31:0] v;
		// hi/lo come out of reset as zero
		run_check(op_mfhi, 0, 0, 0, 0, got);
		run_check(op_mflo, 0, 0, 0, 0, got);
		rand_bits(32, v);
		run_check(op_mthi, v, 0, 0, 0, got);
		rand_bits(32, v);
		run_check(op_mtlo, v, 0, 0, 0, got);
		run_check(op_mfhi, 0, 0, 0, 5, got);
		run_check(op_mflo, 0, 0, 0, 0, got);
		run_check(op_mthi, 32'h0badf00d, 0, 0, 0, got);
		// lo must survive a write to hi
		run_check(op_mflo, 0, 0, 0, 0, got);
		run_check(op_mfhi, 0, 0, 0, 0, got);
		run_check(op_add, 32'h7fffffff, 32'h1, 0, 3, got);
	endtask

	task automatic test_logic_shift();
		alu_op_e ops [11];
		exec_rsp_t got;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sa;
		ops = '{op_and, op_or, op_xor, op_nor, op_lui, op_sll, op_srl, op_sra,
			op_sllv, op_srlv, op_srav};
		repeat (4) begin
			rand_bits(32, a);
			rand_bits(32, b);
			rand_bits(5, sa);
			foreach (ops[i]) begin
				run_check(ops[i], a, b, sa[4:0], 0, got);
			end
		end
	endtask

	task automatic test_arith();
		alu_op_e ops [6];
		exec_rsp_t got;
		logic [31:0] a;
		logic [31:0] b;
		ops = '{op_add, op_addu, op_sub, op_subu, op_slt, op_sltu};
		repeat (3) begin
			rand_bits(32, a);
			rand_bits(32, b);
			foreach (ops[i]) begin
				run_check(ops[i], a, b, 0, 0, got);
			end
		end
		// signed overflow in both directions
		run_check(op_add, 32'h7fffffff, 32'h00000001, 0, 0, got);
		check_eq({got.overflow, got.result}, {1'b1, 32'h0}, "add overflow");
		run_check(op_add, 32'h80000000, 32'h80000000, 0, 0, got);
		check_eq({got.overflow, got.result}, {1'b1, 32'h0}, "add overflow");
		run_check(op_sub, 32'h80000000, 32'h00000001, 0, 0, got);
		check_eq({got.overflow, got.result}, {1'b1, 32'h0}, "sub overflow");
		run_check(op_sub, 32'h7fffffff, 32'hffffffff, 0, 0, got);
		check_eq({got.overflow, got.result}, {1'b1, 32'h0}, "sub overflow");
		run_check(op_addu, 32'h7fffffff, 32'h00000001, 0, 0, got);
		check_eq(got.overflow, 1'b0, "addu overflow flag");
		run_check(op_subu, 32'h80000000, 32'h00000001, 0, 0, got);
		check_eq(got.overflow, 1'b0, "subu overflow flag");
	endtask

	task automatic test_branch();
		alu_op_e ops [6];
		logic [31:0] pa [5];
		logic [31:0] pb [5];
		exec_rsp_t got;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		ops = '{op_beq, op_bne, op_bgtz, op_blez, op_bltz, op_bgez};
		rand_bits(32, r1);
		rand_bits(32, r2);
		rand_bits(32, r3);
		pa = '{32'h0, 32'h80000000, 32'h1, r1, r2};
		pb = '{32'h0, 32'h0, 32'h80000000, r1, r3};
		foreach (ops[i]) begin
			foreach (pa[j]) begin
				run_check(ops[i], pa[j], pb[j], 0, 0, got);
			end
		end
	endtask

	// each mult/div is read back through mfhi and mflo
	task automatic test_muldiv(input alu_op_e op_s, input alu_op_e op_u,
			input logic [31:0] pa [$], input logic [31:0] pb [$]);
		exec_rsp_t got;
		foreach (pa[j]) begin
			run_check(op_s, pa[j], pb[j], 0, 0, got);
			run_check(op_mfhi, 0, 0, 0, 0, got);
			run_check(op_mflo, 0, 0, 0, 0, got);
			run_check(op_u, pa[j], pb[j], 0, 0, got);
			run_check(op_mfhi, 0, 0, 0, 0, got);
			run_check(op_mflo, 0, 0, 0, 0, got);
		end
	endtask

	initial begin
		logic [31:0] r [4];
		rst_n = 1'b0;
		req = 1'b0;
		req_data = '0;
		lfsr = SEED;
		ref_hi = '0;
		ref_lo = '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		test_move();
		test_logic_shift();
		test_arith();
		test_branch();
		foreach (r[i]) begin
			rand_bits(32, r[i]);
		end
		test_muldiv(op_mult, op_multu, '{r[0], r[1], 32'h80000000, 32'hffffffff},
			'{r[2], r[3], 32'h80000000, 32'h00000002});
		test_muldiv(op_div, op_divu, '{r[0], r[1], 32'h12345678, 32'h80000000, 32'hfffffff9},
			'{r[2] >> 8, r[3], 32'h0, 32'hffffffff, 32'h00000002});

		@(posedge clk);
		if (uut.u_assert.fail_count != 0) begin
			$display("error: %0d protocol assertions failed", uut.u_assert.fail_count);
			$display("Simulation failed");
			$fatal(1);
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
logic/exec_pkg.sv
logic/alu.sv
logic/mul_unit.sv
logic/div_unit.sv
logic/hilo_reg.sv
logic/exec_ctrl.sv
logic/exec_top.sv
testbench/exec_assert.sv
testbench/exec_tb.sv

//--- Bender.yml
package:
  name: exec_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/exec_pkg.sv
      - logic/alu.sv
      - logic/mul_unit.sv
      - logic/div_unit.sv
      - logic/hilo_reg.sv
      - logic/exec_ctrl.sv
      - logic/exec_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/exec_assert.sv
      - testbench/exec_tb.sv
